// ==== src.f ====
rtl/apu_pkg.sv
rtl/apu_dispatch.sv
rtl/apu_lane.sv
rtl/apu_collect.sv
rtl/apu_wrapper.sv
verif/apu_tb.sv

// ==== Makefile ====
# Verilator simulation of the APU testbench

VERILATOR ?= verilator
TOP       ?= apu_tb
APU_EN    ?= 1
NUM_LANES ?= 4
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f src.f --top-module $(TOP) \
		-GAPU_EN=$(APU_EN) -GNUM_LANES=$(NUM_LANES) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/apu_tb.sv ====
// APU testbench: reference model, scoreboard, concurrent checks, xorshift stimulus, watchdog

`timescale 1ns/1ps

module apu_tb #(
  parameter int APU_EN    = 1,
  parameter int NUM_LANES = 4
);

  import apu_pkg::*;

  localparam int N_SHORT    = 40;
  localparam int N_LONG     = 24;
  // Random, directed, burst and illegal requests together
  localparam int TOTAL_REQS = N_SHORT + N_LONG + 8 + NUM_LANES + 8 + 8;
  localparam int WATCHDOG_CYCLES = TOTAL_REQS * 40 * NUM_LANES + 500;

  logic                                clk_i;
  logic                                reset_i;
  logic                                apu_req_i;
  logic                                apu_gnt_o;
  logic [APU_NARGS-1:0][31:0]          apu_operands_i;
  logic [APU_WOP-1:0]                  apu_op_i;
  logic [APU_NDSFLAGS-1:0]             apu_flags_i;
  logic                                apu_rvalid_o;
  logic [31:0]                         apu_rdata_o;
  logic [APU_NUSFLAGS-1:0]             apu_rflags_o;

  // Scoreboard, oldest expected response first
  logic [31:0]             sb_data[$];
  logic [APU_NUSFLAGS-1:0] sb_flags[$];
  int                      sb_count = 0;
  logic [31:0]             head_data = '0;
  logic [APU_NUSFLAGS-1:0] head_flags = '0;

  // Bookkeeping
  string       test_name = "reset";
  int          err_count = 0;
  int          check_count = 0;
  int          test_count = 0;
  int          err_mark = 0;
  int          check_mark = 0;
  logic [31:0] rng_state = 32'h8811_38d0;

  apu_wrapper #(
    .APU_EN    (APU_EN),
    .NUM_LANES (NUM_LANES)
  ) u_dut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .apu_req_i      (apu_req_i),
    .apu_gnt_o      (apu_gnt_o),
    .apu_operands_i (apu_operands_i),
    .apu_op_i       (apu_op_i),
    .apu_flags_i    (apu_flags_i),
    .apu_rvalid_o   (apu_rvalid_o),
    .apu_rdata_o    (apu_rdata_o),
    .apu_rflags_o   (apu_rflags_o)
  );

  // 8 ns clock
  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Expected {flags, data} from the RISC-V style operation rules
  function automatic logic [34:0] model_result(input logic [3:0] op, input logic [31:0] a,
                                               input logic [31:0] b, input logic sgn);
    logic [31:0] res;
    logic [2:0]  flg;
    logic        lt;
    logic        ovf;
    res = '0;
    flg = '0;
    lt  = sgn ? ($signed(a) < $signed(b)) : (a < b);
    ovf = sgn && (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      APU_ADD: res = a + b;
      APU_SUB: res = a - b;
      APU_SLT: res = {31'd0, lt};
      APU_MIN: res = lt ? a : b;
      APU_MAX: res = lt ? b : a;
      APU_MUL: res = a * b;
      APU_DIV: begin
        if (b == 32'd0) begin
          res = '1;
          flg[APU_FLAG_DIVZ] = 1'b1;
        end else if (ovf) begin
          res = a;
        end else if (sgn) begin
          res = $signed(a) / $signed(b);
        end else begin
          res = a / b;
        end
      end
      APU_REM: begin
        if (b == 32'd0) begin
          res = a;
          flg[APU_FLAG_DIVZ] = 1'b1;
        end else if (ovf) begin
          res = '0;
        end else if (sgn) begin
          res = $signed(a) % $signed(b);
        end else begin
          res = a % b;
        end
      end
      default: flg[APU_FLAG_ILLEGAL] = 1'b1;
    endcase
    flg[APU_FLAG_ZERO] = (res == 32'd0);
    return {flg, res};
  endfunction

  function automatic void refresh_head();
    sb_count = sb_data.size();
    if (sb_count > 0) begin
      head_data  = sb_data[0];
      head_flags = sb_flags[0];
    end
  endfunction

  // Pop after the negedge check has seen the response
  always @(posedge clk_i) begin
    if (!reset_i && apu_rvalid_o && (sb_count > 0)) begin
      void'(sb_data.pop_front());
      void'(sb_flags.pop_front());
      check_count++;
      refresh_head();
    end
  end

  // Outputs are registered, so they are settled at the falling edge
  data_check: assert property (@(negedge clk_i) disable iff (reset_i)
    apu_rvalid_o |-> (apu_rdata_o == head_data) && (apu_rflags_o == head_flags))
  else begin
    $display("error %s: expected %08h flags %03b, actual %08h flags %03b",
             test_name, head_data, head_flags, apu_rdata_o, apu_rflags_o);
    err_count++;
  end

  inflight_check: assert property (@(negedge clk_i) disable iff (reset_i)
    sb_count <= NUM_LANES)
  else begin
    $display("%s: more than %0d requests in flight", test_name, NUM_LANES);
    err_count++;
  end

  spurious_check: assert property (@(negedge clk_i) disable iff (reset_i)
    apu_rvalid_o |-> (sb_count > 0))
  else begin
    $display("%s: response arrived with no request outstanding", test_name);
    err_count++;
  end

  // Called at a falling edge, returns at the falling edge after the transfer
  task automatic send(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b,
                      input logic sgn, input logic expect_stall);
    logic [34:0] expected;
    expected          = model_result(op, a, b, sgn);
    apu_req_i         = 1'b1;
    apu_op_i          = op;
    apu_operands_i[0] = a;
    apu_operands_i[1] = b;
    apu_flags_i       = sgn;
    #1;
    if (expect_stall) begin
      assert (!apu_gnt_o) else begin
        $display("%s: grant given while every lane was busy", test_name);
        err_count++;
      end
    end
    // Grant is stable between the falling and the rising edge
    while (!apu_gnt_o) begin
      @(negedge clk_i);
      #1;
    end
    sb_data.push_back(expected[31:0]);
    sb_flags.push_back(expected[34:32]);
    refresh_head();
    @(negedge clk_i);
    apu_req_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (sb_count != 0) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
  endtask

  task automatic begin_test(input string name);
    test_name  = name;
    err_mark   = err_count;
    check_mark = check_count;
  endtask

  task automatic finish_test();
    test_count++;
    $display("test %-8s %s (%0d responses, %0d errors)", test_name,
             (err_count == err_mark) ? "ok" : "FAILED",
             check_count - check_mark, err_count - err_mark);
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    apu_req_i      = 1'b0;
    apu_operands_i = '0;
    apu_op_i       = '0;
    apu_flags_i    = '0;
    reset_i        = 1'b1;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // Idle port right after reset
    begin_test("reset");
    #1;
    assert (!apu_gnt_o && !apu_rvalid_o) else begin
      $display("reset: grant or rvalid high after reset");
      err_count++;
    end
    @(negedge clk_i);
    finish_test();

    if (APU_EN == 0) begin
      // Held request must never be granted
      begin_test("no_apu");
      apu_req_i = 1'b1;
      apu_op_i  = APU_ADD;
      repeat (200) begin
        #1;
        assert (!apu_gnt_o && !apu_rvalid_o) else begin
          $display("no_apu: absent unit granted or responded");
          err_count++;
        end
        @(negedge clk_i);
      end
      apu_req_i = 1'b0;
      finish_test();
    end else begin
      begin_test("alu");
      for (int i = 0; i < N_SHORT; i++) begin
        a = next_rand();
        b = next_rand();
        r = next_rand();
        // Equal operands now and then to hit the zero flag
        if (r[12:10] == 3'd0) begin
          b = a;
        end
        send(4'(r % 32'd5), a, b, r[8], 1'b0);
      end
      wait_drain();
      finish_test();

      begin_test("muldiv");
      for (int i = 0; i < N_LONG; i++) begin
        a = next_rand();
        r = next_rand();
        b = next_rand() >> r[20:16];
        send(4'(32'd5 + (r % 32'd3)), a, b, r[8], 1'b0);
      end
      // Zero divisor and signed overflow corners
      send(APU_DIV, 32'h1234_5678, 32'd0, 1'b0, 1'b0);
      send(APU_REM, 32'h1234_5678, 32'd0, 1'b0, 1'b0);
      send(APU_DIV, 32'hffff_fff9, 32'd0, 1'b1, 1'b0);
      send(APU_REM, 32'd0, 32'd0, 1'b1, 1'b0);
      send(APU_DIV, 32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b0);
      send(APU_REM, 32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b0);
      send(APU_DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b0);
      send(APU_REM, 32'hffff_fff9, 32'd2, 1'b1, 1'b0);
      wait_drain();
      finish_test();

      // Fill every lane with a multiply, then mix short and long behind them
      begin_test("burst");
      for (int i = 0; i < NUM_LANES; i++) begin
        send(APU_MUL, next_rand(), next_rand(), 1'b0, 1'b0);
      end
      for (int i = 0; i < 8; i++) begin
        r = next_rand();
        if (i % 2 == 0) begin
          send(4'(r % 32'd5), next_rand(), next_rand(), r[8], i == 0);
        end else begin
          send(4'(32'd5 + (r % 32'd3)), next_rand(), next_rand(), r[8], 1'b0);
        end
      end
      wait_drain();
      finish_test();

      begin_test("illegal");
      for (int i = 8; i < 16; i++) begin
        send(4'(i), next_rand(), next_rand(), i[0], 1'b0);
      end
      wait_drain();
      finish_test();
    end

    $display("tests %0d, responses %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Hang guard sized from the request count
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== rtl/apu_wrapper.sv ====
// APU top level: dispatcher, lane array and collector, or a tied-off response port

`timescale 1ns/1ps

module apu_wrapper #(
  // Build the unit at all
  parameter int APU_EN    = 1,
  // Number of arithmetic lanes, 1 to 8
  parameter int NUM_LANES = 4
) (
  input  logic                                       clk_i,
  input  logic                                       reset_i,

  // Request side
  input  logic                                       apu_req_i,
  output logic                                       apu_gnt_o,
  input  logic [apu_pkg::APU_NARGS-1:0][31:0]        apu_operands_i,
  input  logic [apu_pkg::APU_WOP-1:0]                apu_op_i,
  input  logic [apu_pkg::APU_NDSFLAGS-1:0]           apu_flags_i,

  // Response side, no back-pressure
  output logic                                       apu_rvalid_o,
  output logic [31:0]                                apu_rdata_o,
  output logic [apu_pkg::APU_NUSFLAGS-1:0]           apu_rflags_o
);

  import apu_pkg::*;

  generate
    if (APU_EN != 0) begin : apu_gen
      // Opcode as enum, illegal codes keep their raw value
      apu_op_e                                op_enum;

      // Lane handshake
      logic [NUM_LANES-1:0]                   lane_issue;
      logic [NUM_LANES-1:0]                   lane_retire;
      logic [NUM_LANES-1:0]                   lane_idle;
      logic [NUM_LANES-1:0]                   lane_done;

      // Lane results
      logic [NUM_LANES-1:0][31:0]             lane_result;
      logic [NUM_LANES-1:0][APU_NUSFLAGS-1:0] lane_rflags;

      assign op_enum = apu_op_e'(apu_op_i);

      // Grant and issue in strict rotation
      apu_dispatch #(
        .NUM_LANES (NUM_LANES)
      ) u_dispatch (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_i       (apu_req_i),
        .lane_idle_i (lane_idle),
        .gnt_o       (apu_gnt_o),
        .issue_o     (lane_issue)
      );

      // Payload is broadcast, only the issued lane captures it
      for (genvar k = 0; k < NUM_LANES; k++) begin : lane_gen
        apu_lane u_lane (
          .clk_i       (clk_i),
          .reset_i     (reset_i),
          .issue_i     (lane_issue[k]),
          .retire_i    (lane_retire[k]),
          .op_i        (op_enum),
          .operand_a_i (apu_operands_i[0]),
          .operand_b_i (apu_operands_i[1]),
          .signed_i    (apu_flags_i[0]),
          .idle_o      (lane_idle[k]),
          .done_o      (lane_done[k]),
          .result_o    (lane_result[k]),
          .rflags_o    (lane_rflags[k])
        );
      end

      // Retire in the same rotation, restoring grant order
      apu_collect #(
        .NUM_LANES (NUM_LANES)
      ) u_collect (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .lane_done_i   (lane_done),
        .lane_result_i (lane_result),
        .lane_rflags_i (lane_rflags),
        .retire_o      (lane_retire),
        .rvalid_o      (apu_rvalid_o),
        .rdata_o       (apu_rdata_o),
        .rflags_o      (apu_rflags_o)
      );
    end else begin : no_apu_gen
      // Unit absent, requests are never granted
      assign apu_gnt_o    = 1'b0;
      assign apu_rvalid_o = 1'b0;
      assign apu_rdata_o  = '0;
      assign apu_rflags_o = '0;
    end
  endgenerate

endmodule

// ==== rtl/apu_collect.sv ====
// APU collector: in-order retirement of lane results onto the registered response port

`timescale 1ns/1ps

module apu_collect #(
  parameter int NUM_LANES = 4
) (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  input  logic [NUM_LANES-1:0]                             lane_done_i,
  input  logic [NUM_LANES-1:0][31:0]                       lane_result_i,
  input  logic [NUM_LANES-1:0][apu_pkg::APU_NUSFLAGS-1:0]  lane_rflags_i,
  output logic [NUM_LANES-1:0]                             retire_o,
  output logic                                             rvalid_o,
  output logic [31:0]                                      rdata_o,
  output logic [apu_pkg::APU_NUSFLAGS-1:0]                 rflags_o
);

  import apu_pkg::*;

  // Pointer width, at least one bit even for a single lane
  localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  // Oldest outstanding lane, same rotation as the dispatcher
  logic [LW-1:0]           head_q;
  logic [LW-1:0]           head_next;
  logic                    head_done;

  // Response registers
  logic                    rvalid_q;
  logic [31:0]             rdata_q;
  logic [APU_NUSFLAGS-1:0] rflags_q;

  // A younger lane that finishes first simply waits in DONE
  assign head_done = lane_done_i[head_q];

  // Retire pulse frees the head lane at the same edge the result is taken
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      retire_o[k] = head_done && (head_q == LW'(k));
    end
  end

  // Wrap after the last lane
  always_comb begin
    if (head_q == LW'(NUM_LANES - 1)) begin
      head_next = '0;
    end else begin
      head_next = head_q + 1'b1;
    end
  end

  // Head pointer and valid pulse
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= head_done;
      if (head_done) begin
        head_q <= head_next;
      end
    end
  end

  // Payload, only meaningful while rvalid is high
  always_ff @(posedge clk_i) begin
    if (head_done) begin
      rdata_q  <= lane_result_i[head_q];
      rflags_q <= lane_rflags_i[head_q];
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign rflags_o = rflags_q;

endmodule

// ==== rtl/apu_lane.sv ====
// APU lane: single-cycle ALU ops plus 32-step shift-add multiply and restoring divide

`timescale 1ns/1ps

module apu_lane (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             issue_i,
  input  logic                             retire_i,
  input  apu_pkg::apu_op_e                 op_i,
  input  logic [31:0]                      operand_a_i,
  input  logic [31:0]                      operand_b_i,
  input  logic                             signed_i,
  output logic                             idle_o,
  output logic                             done_o,
  output logic [31:0]                      result_o,
  output logic [apu_pkg::APU_NUSFLAGS-1:0] rflags_o
);

  import apu_pkg::*;

  // Iteration count for multiply and divide
  localparam int STEPS = 32;

  // Control state
  lane_state_e             state_q;
  logic [5:0]              step_q;

  // Latched request
  apu_op_e                 op_q;
  logic                    signed_q;
  logic [31:0]             a_q;
  logic [31:0]             b_q;

  // Iteration registers
  // work_a: MUL multiplier, DIV quotient with dividend shifting out
  // work_b: MUL multiplicand, DIV divisor magnitude
  // acc: MUL product, DIV partial remainder
  logic [31:0]             work_a_q;
  logic [31:0]             work_b_q;
  logic [32:0]             acc_q;

  // Registered response
  logic [31:0]             result_q;
  logic [APU_NUSFLAGS-1:0] rflags_q;

  // Combinational helpers
  logic                    iterative;
  logic                    last_step;
  logic                    finish;
  logic                    less_than;
  logic [31:0]             a_mag;
  logic [31:0]             b_mag;
  logic [32:0]             rem_shift;
  logic [32:0]             rem_diff;
  logic [31:0]             quo_fix;
  logic [31:0]             rem_fix;
  logic [31:0]             next_result;
  logic [APU_NUSFLAGS-1:0] next_flags;

  assign iterative = (op_q == APU_MUL) || (op_q == APU_DIV) || (op_q == APU_REM);
  assign last_step = (step_q == 6'(STEPS));

  // Response is written in the BUSY cycle that ends the operation
  assign finish = (state_q == LANE_BUSY) && (!iterative || last_step);

  // Operand magnitudes for signed division, taken straight from the request
  assign a_mag = (signed_i && operand_a_i[31]) ? -operand_a_i : operand_a_i;
  assign b_mag = (signed_i && operand_b_i[31]) ? -operand_b_i : operand_b_i;

  // Restoring divide step, borrow in bit 32 means the divisor did not fit
  assign rem_shift = {acc_q[31:0], work_a_q[31]};
  assign rem_diff  = rem_shift - {1'b0, work_b_q};

  // Comparison shared by SLT, MIN and MAX
  assign less_than = signed_q ? ($signed(a_q) < $signed(b_q)) : (a_q < b_q);

  // Sign fix after division
  // Quotient negative when operand signs differ, remainder takes the dividend sign
  // Signed overflow falls out naturally as 0x80000000 quotient, zero remainder
  assign quo_fix = (signed_q && (a_q[31] ^ b_q[31])) ? -work_a_q : work_a_q;
  assign rem_fix = (signed_q && a_q[31]) ? -acc_q[31:0] : acc_q[31:0];

  // Final result selection
  always_comb begin
    next_result = '0;
    next_flags  = '0;
    case (op_q)
      APU_ADD: next_result = a_q + b_q;
      APU_SUB: next_result = a_q - b_q;
      APU_SLT: next_result = {31'd0, less_than};
      APU_MIN: next_result = less_than ? a_q : b_q;
      APU_MAX: next_result = less_than ? b_q : a_q;
      APU_MUL: next_result = acc_q[31:0];
      APU_DIV: begin
        // Zero divisor gives all ones
        if (b_q == '0) begin
          next_result              = '1;
          next_flags[APU_FLAG_DIVZ] = 1'b1;
        end else begin
          next_result = quo_fix;
        end
      end
      APU_REM: begin
        // Zero divisor returns the dividend
        if (b_q == '0) begin
          next_result              = a_q;
          next_flags[APU_FLAG_DIVZ] = 1'b1;
        end else begin
          next_result = rem_fix;
        end
      end
      default: next_flags[APU_FLAG_ILLEGAL] = 1'b1;
    endcase
    next_flags[APU_FLAG_ZERO] = (next_result == '0);
  end

  // Lane FSM
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= LANE_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        LANE_IDLE: begin
          if (issue_i) begin
            state_q <= LANE_BUSY;
            step_q  <= '0;
          end
        end
        LANE_BUSY: begin
          if (finish) begin
            state_q <= LANE_DONE;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        LANE_DONE: begin
          // Hold the result until the collector takes it
          if (retire_i) begin
            state_q <= LANE_IDLE;
          end
        end
        default: state_q <= LANE_IDLE;
      endcase
    end
  end

  // Request capture and iteration datapath
  always_ff @(posedge clk_i) begin
    if (issue_i && (state_q == LANE_IDLE)) begin
      op_q     <= op_i;
      signed_q <= signed_i;
      a_q      <= operand_a_i;
      b_q      <= operand_b_i;
      acc_q    <= '0;
      // Low 32 product bits do not depend on signedness
      if (op_i == APU_MUL) begin
        work_a_q <= operand_a_i;
        work_b_q <= operand_b_i;
      end else begin
        work_a_q <= a_mag;
        work_b_q <= b_mag;
      end
    end else if ((state_q == LANE_BUSY) && iterative && !last_step) begin
      if (op_q == APU_MUL) begin
        if (work_a_q[0]) begin
          acc_q <= {1'b0, acc_q[31:0] + work_b_q};
        end
        work_a_q <= work_a_q >> 1;
        work_b_q <= work_b_q << 1;
      end else if (!rem_diff[32]) begin
        acc_q    <= rem_diff;
        work_a_q <= {work_a_q[30:0], 1'b1};
      end else begin
        acc_q    <= rem_shift;
        work_a_q <= {work_a_q[30:0], 1'b0};
      end
    end
  end

  // Response register
  always_ff @(posedge clk_i) begin
    if (finish) begin
      result_q <= next_result;
      rflags_q <= next_flags;
    end
  end

  assign idle_o   = (state_q == LANE_IDLE);
  assign done_o   = (state_q == LANE_DONE);
  assign result_o = result_q;
  assign rflags_o = rflags_q;

endmodule

// ==== rtl/apu_dispatch.sv ====
// APU dispatcher: round-robin request grant and issue steering to the arithmetic lanes

`timescale 1ns/1ps

module apu_dispatch #(
  parameter int NUM_LANES = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 req_i,
  input  logic [NUM_LANES-1:0] lane_idle_i,
  output logic                 gnt_o,
  output logic [NUM_LANES-1:0] issue_o
);

  // Pointer width, at least one bit even for a single lane
  localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  // Lane that receives the next granted request
  logic [LW-1:0] ptr_q;
  logic [LW-1:0] ptr_next;

  // Target lane is free
  logic          target_idle;

  // Only the lane under the pointer is considered
  // Skipping a busy lane would break the order the collector relies on
  assign target_idle = lane_idle_i[ptr_q];

  // Grant follows the request in the same cycle
  assign gnt_o = req_i && target_idle;

  // One-hot issue pulse towards the targeted lane
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      issue_o[k] = gnt_o && (ptr_q == LW'(k));
    end
  end

  // Wrap after the last lane
  always_comb begin
    if (ptr_q == LW'(NUM_LANES - 1)) begin
      ptr_next = '0;
    end else begin
      ptr_next = ptr_q + 1'b1;
    end
  end

  // Pointer moves on every accepted transfer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (gnt_o) begin
      ptr_q <= ptr_next;
    end
  end

endmodule

// ==== rtl/apu_pkg.sv ====
// APU package: opcode enum, port widths, result flag positions and lane state type

package apu_pkg;

  // Opcode field width on the request port
  localparam int APU_WOP = 4;

  // Two operand words per request
  localparam int APU_NARGS = 2;

  // Request flags, bit 0 selects signed mode
  localparam int APU_NDSFLAGS = 1;

  // Result flags returned alongside rdata
  localparam int APU_NUSFLAGS = 3;

  // Result flag bit positions
  localparam int APU_FLAG_ZERO    = 0;
  localparam int APU_FLAG_DIVZ    = 1;
  localparam int APU_FLAG_ILLEGAL = 2;

  // Supported operations, codes 8 to 15 are illegal
  typedef enum logic [APU_WOP-1:0] {
    APU_ADD = 4'd0,
    APU_SUB = 4'd1,
    APU_SLT = 4'd2,
    APU_MIN = 4'd3,
    APU_MAX = 4'd4,
    APU_MUL = 4'd5,
    APU_DIV = 4'd6,
    APU_REM = 4'd7
  } apu_op_e;

  // Lane FSM states
  typedef enum logic [1:0] {
    LANE_IDLE = 2'd0,
    LANE_BUSY = 2'd1,
    LANE_DONE = 2'd2
  } lane_state_e;

endpackage
